// File: rtl/chdr_pkg.sv
//////////////////////////////////////////////////
// Shared types and helpers for the CHDR loopback
// endpoint. Modules take these by a wildcard
// import in the body and scoped names in ports.
//////////////////////////////////////////////////

package chdr_pkg;

   // Default stream data width
   localparam int DATA_W = 64;

   // Stream ID is endpoint address over port number
   localparam int SID_W  = 16;
   localparam int ADDR_W = 8;

   typedef logic [SID_W-1:0]  sid_t;
   typedef logic [ADDR_W-1:0] ep_addr_t;

   // One AXI-stream transfer, last sits above the data like {tlast, tdata}
   typedef struct packed {
      logic              last;
      logic [DATA_W-1:0] data;
   } axis_beat_t;

   // Header word layout, bits 63:32 carry the CHDR control word untouched
   localparam int HDR_DST_LSB = 0;
   localparam int HDR_SRC_LSB = 16;

   // Exchange the source and destination SID halves of a header word
   function automatic logic [DATA_W-1:0] sid_swap(input logic [DATA_W-1:0] hdr);
      sid_t              src_sid;
      sid_t              dst_sid;
      logic [DATA_W-1:0] swapped;
      src_sid = hdr[HDR_SRC_LSB +: SID_W];
      dst_sid = hdr[HDR_DST_LSB +: SID_W];
      swapped = hdr;
      swapped[HDR_SRC_LSB +: SID_W] = dst_sid;
      swapped[HDR_DST_LSB +: SID_W] = src_sid;
      return swapped;
   endfunction

   // Endpoint address of the destination SID in a header word
   function automatic ep_addr_t dst_endpoint(input logic [DATA_W-1:0] hdr);
      sid_t dst_sid;
      dst_sid = hdr[HDR_DST_LSB +: SID_W];
      return dst_sid[SID_W-1 -: ADDR_W];
   endfunction

endpackage

// File: rtl/axis_short_fifo.sv
//////////////////////////////////////////////////
// Small AXI-stream FIFO holding whole beat structs.
// Depth is a power of two, at least 2. A beat
// written into an empty FIFO is valid one cycle on.
//////////////////////////////////////////////////

module axis_short_fifo #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                 clk,
   input  logic                 reset,
   // Write side
   input  chdr_pkg::axis_beat_t i_beat,
   input  logic                 i_valid,
   output logic                 o_ready,
   // Read side
   output chdr_pkg::axis_beat_t o_beat,
   output logic                 o_valid,
   input  logic                 i_ready
);

   import chdr_pkg::*;

   localparam int PTR_W = $clog2(FIFO_DEPTH);
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   axis_beat_t       mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             push;
   logic             pop;

   // Full blocks the writer, empty hides the reader
   assign o_ready = (count != CNT_W'(FIFO_DEPTH));
   assign o_valid = (count != '0);

   assign push = i_valid & o_ready;
   assign pop  = o_valid & i_ready;

   // Head entry comes straight out of the storage flops
   assign o_beat = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= i_beat;
      end
   end

   // Pointers wrap on their own since the depth is a power of two
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + PTR_W'(1);
         end
         if (pop) begin
            rd_ptr <= rd_ptr + PTR_W'(1);
         end
      end
   end

   // Occupancy holds when a push and a pop land together
   always_ff @(posedge clk) begin
      if (reset) begin
         count <= '0;
      end else begin
         case ({push, pop})
            2'b10: begin
               count <= count + CNT_W'(1);
            end
            2'b01: begin
               count <= count - CNT_W'(1);
            end
            default: begin
               count <= count;
            end
         endcase
      end
   end

endmodule

// File: rtl/chdr_dest_demux.sv
//////////////////////////////////////////////////
// Per-packet router. The header beat's destination
// endpoint picks the local or the forward output
// and the choice holds until the last beat leaves.
//////////////////////////////////////////////////

module chdr_dest_demux #(
   parameter chdr_pkg::ep_addr_t LOCAL_ADDR = 8'h00
) (
   input  logic                 clk,
   input  logic                 reset,
   // Packet input
   input  chdr_pkg::axis_beat_t i_beat,
   input  logic                 i_valid,
   output logic                 o_ready,
   // Packets addressed to this endpoint
   output chdr_pkg::axis_beat_t o_loc_beat,
   output logic                 o_loc_valid,
   input  logic                 i_loc_ready,
   // Everything else
   output chdr_pkg::axis_beat_t o_fwd_beat,
   output logic                 o_fwd_valid,
   input  logic                 i_fwd_ready
);

   import chdr_pkg::*;

   logic     in_hdr;
   logic     route_loc_q;
   logic     hdr_is_loc;
   logic     sel_loc;
   logic     xfer;
   ep_addr_t hdr_dst;

   // Destination of the beat on the input, meaningful on headers only
   assign hdr_dst    = dst_endpoint(i_beat.data);
   assign hdr_is_loc = (hdr_dst == LOCAL_ADDR);

   // Header decides now, body beats follow the latched route
   assign sel_loc = in_hdr ? hdr_is_loc : route_loc_q;

   // Both outputs see the beat, valid goes only one way
   assign o_loc_beat  = i_beat;
   assign o_fwd_beat  = i_beat;
   assign o_loc_valid = i_valid & sel_loc;
   assign o_fwd_valid = i_valid & ~sel_loc;

   assign o_ready = sel_loc ? i_loc_ready : i_fwd_ready;
   assign xfer    = i_valid & o_ready;

   // Header flag is back up after a last beat
   always_ff @(posedge clk) begin
      if (reset) begin
         in_hdr <= 1'b1;
      end else if (xfer) begin
         in_hdr <= i_beat.last;
      end
   end

   // Route is captured on the header transfer
   always_ff @(posedge clk) begin
      if (reset) begin
         route_loc_q <= 1'b0;
      end else if (xfer && in_hdr) begin
         route_loc_q <= hdr_is_loc;
      end
   end

endmodule

// File: rtl/chdr_sid_swap.sv
//////////////////////////////////////////////////
// Zero-latency header rewriter. The first beat of
// each packet gets its source and destination SIDs
// exchanged; body beats pass untouched.
//////////////////////////////////////////////////

module chdr_sid_swap (
   input  logic                 clk,
   input  logic                 reset,
   // Upstream
   input  chdr_pkg::axis_beat_t i_beat,
   input  logic                 i_valid,
   output logic                 o_ready,
   // Downstream
   output chdr_pkg::axis_beat_t o_beat,
   output logic                 o_valid,
   input  logic                 i_ready
);

   import chdr_pkg::*;

   logic in_hdr;
   logic xfer;

   // Handshake passes straight through
   assign o_valid = i_valid;
   assign o_ready = i_ready;
   assign xfer    = i_valid & i_ready;

   assign o_beat.last = i_beat.last;
   assign o_beat.data = in_hdr ? sid_swap(i_beat.data) : i_beat.data;

   // Set on reset and after last, cleared after any other beat
   always_ff @(posedge clk) begin
      if (reset) begin
         in_hdr <= 1'b1;
      end else if (xfer) begin
         in_hdr <= i_beat.last;
      end
   end

endmodule

// File: rtl/chdr_loopback.sv
//////////////////////////////////////////////////
// CHDR loopback endpoint top. Local packets come
// back on the loop port with SIDs swapped, two
// cycles late; other packets go out on forward.
//////////////////////////////////////////////////

module chdr_loopback #(
   parameter chdr_pkg::ep_addr_t LOCAL_ADDR = 8'h00,
   parameter int                 FIFO_DEPTH = 4
) (
   input  logic                        clk,
   input  logic                        reset,
   // Packet input
   input  logic [chdr_pkg::DATA_W-1:0] i_tdata,
   input  logic                        i_tlast,
   input  logic                        i_tvalid,
   output logic                        o_tready,
   // Reflected packets
   output logic [chdr_pkg::DATA_W-1:0] o_loop_tdata,
   output logic                        o_loop_tlast,
   output logic                        o_loop_tvalid,
   input  logic                        i_loop_tready,
   // Passed-on packets
   output logic [chdr_pkg::DATA_W-1:0] o_fwd_tdata,
   output logic                        o_fwd_tlast,
   output logic                        o_fwd_tvalid,
   input  logic                        i_fwd_tready
);

   import chdr_pkg::*;

   axis_beat_t in_beat;
   axis_beat_t fwd_beat;
   axis_beat_t demux_loc_beat;
   logic       demux_loc_valid;
   logic       demux_loc_ready;
   axis_beat_t fifo1_out_beat;
   logic       fifo1_out_valid;
   logic       fifo1_out_ready;
   axis_beat_t swap_out_beat;
   logic       swap_out_valid;
   logic       swap_out_ready;
   axis_beat_t loop_beat;

   assign in_beat.data = i_tdata;
   assign in_beat.last = i_tlast;

   chdr_dest_demux #(
      .LOCAL_ADDR(LOCAL_ADDR)
   ) demux_i (
      .clk         (clk),
      .reset       (reset),
      .i_beat      (in_beat),
      .i_valid     (i_tvalid),
      .o_ready     (o_tready),
      .o_loc_beat  (demux_loc_beat),
      .o_loc_valid (demux_loc_valid),
      .i_loc_ready (demux_loc_ready),
      .o_fwd_beat  (fwd_beat),
      .o_fwd_valid (o_fwd_tvalid),
      .i_fwd_ready (i_fwd_tready)
   );

   axis_short_fifo #(
      .FIFO_DEPTH(FIFO_DEPTH)
   ) fifo1_i (
      .clk     (clk),
      .reset   (reset),
      .i_beat  (demux_loc_beat),
      .i_valid (demux_loc_valid),
      .o_ready (demux_loc_ready),
      .o_beat  (fifo1_out_beat),
      .o_valid (fifo1_out_valid),
      .i_ready (fifo1_out_ready)
   );

   chdr_sid_swap swap_i (
      .clk     (clk),
      .reset   (reset),
      .i_beat  (fifo1_out_beat),
      .i_valid (fifo1_out_valid),
      .o_ready (fifo1_out_ready),
      .o_beat  (swap_out_beat),
      .o_valid (swap_out_valid),
      .i_ready (swap_out_ready)
   );

   // Second FIFO keeps the swap logic off the loop output
   axis_short_fifo #(
      .FIFO_DEPTH(FIFO_DEPTH)
   ) fifo2_i (
      .clk     (clk),
      .reset   (reset),
      .i_beat  (swap_out_beat),
      .i_valid (swap_out_valid),
      .o_ready (swap_out_ready),
      .o_beat  (loop_beat),
      .o_valid (o_loop_tvalid),
      .i_ready (i_loop_tready)
   );

   assign o_loop_tdata = loop_beat.data;
   assign o_loop_tlast = loop_beat.last;
   assign o_fwd_tdata  = fwd_beat.data;
   assign o_fwd_tlast  = fwd_beat.last;

endmodule

// File: testbench/chdr_loopback_assertions.sv
//////////////////////////////////////////////////
// Bound checker for the CHDR loopback top. Models
// the routing and SID swap with expected-beat
// queues and checks every output transfer.
//////////////////////////////////////////////////

module chdr_loopback_chk #(
   parameter chdr_pkg::ep_addr_t LOCAL_ADDR = 8'h00
) (
   input logic                        clk,
   input logic                        reset,
   input logic [chdr_pkg::DATA_W-1:0] i_tdata,
   input logic                        i_tlast,
   input logic                        i_tvalid,
   input logic                        o_tready,
   input logic [chdr_pkg::DATA_W-1:0] o_loop_tdata,
   input logic                        o_loop_tlast,
   input logic                        o_loop_tvalid,
   input logic                        i_loop_tready,
   input logic [chdr_pkg::DATA_W-1:0] o_fwd_tdata,
   input logic                        o_fwd_tlast,
   input logic                        o_fwd_tvalid,
   input logic                        i_fwd_tready
);

   import chdr_pkg::*;

   axis_beat_t        loc_q[$];
   axis_beat_t        fwd_q[$];
   axis_beat_t        exp_beat;
   axis_beat_t        loc_head_q;
   axis_beat_t        fwd_head_q;
   logic              loc_pend_q;
   logic              fwd_pend_q;
   logic              in_hdr;
   logic              route_loc_q;
   logic              route_loc;
   logic              in_xfer;
   logic              loop_xfer;
   logic              fwd_xfer;
   logic              fwd_avail;
   logic [DATA_W-1:0] loc_exp_data;
   logic [DATA_W-1:0] fwd_exp_data;
   logic              loc_exp_last;
   logic              fwd_exp_last;
   int                error_count = 0;
   int                pending = 0;

   assign in_xfer   = i_tvalid & o_tready;
   assign loop_xfer = o_loop_tvalid & i_loop_tready;
   assign fwd_xfer  = o_fwd_tvalid & i_fwd_tready;

   // Header beats pick the route, body beats keep it
   // Destination endpoint is the upper byte of the SID in bits 15:0
   assign route_loc     = in_hdr ? (i_tdata[15:8] == LOCAL_ADDR) : route_loc_q;
   assign exp_beat.last = i_tlast;
   // Local headers come back with the SID halves in bits 31:16 and 15:0 exchanged
   assign exp_beat.data = (in_hdr && route_loc) ?
      {i_tdata[DATA_W-1:32], i_tdata[15:0], i_tdata[31:16]} : i_tdata;

   // Forward path has no latency, so an empty queue means the beat is on the input now
   assign fwd_avail    = fwd_pend_q | (in_xfer & ~route_loc);
   assign fwd_exp_data = fwd_pend_q ? fwd_head_q.data : exp_beat.data;
   assign fwd_exp_last = fwd_pend_q ? fwd_head_q.last : exp_beat.last;
   assign loc_exp_data = loc_head_q.data;
   assign loc_exp_last = loc_head_q.last;

   always @(posedge clk) begin
      if (reset) begin
         loc_q.delete();
         fwd_q.delete();
         in_hdr      <= 1'b1;
         route_loc_q <= 1'b0;
      end else begin
         if (in_xfer) begin
            if (route_loc) begin
               loc_q.push_back(exp_beat);
            end else begin
               fwd_q.push_back(exp_beat);
            end
            in_hdr <= i_tlast;
            if (in_hdr) begin
               route_loc_q <= route_loc;
            end
         end
         if (loop_xfer && loc_q.size() != 0) begin
            void'(loc_q.pop_front());
         end
         if (fwd_xfer && fwd_q.size() != 0) begin
            void'(fwd_q.pop_front());
         end
      end
      loc_pend_q <= (loc_q.size() != 0);
      fwd_pend_q <= (fwd_q.size() != 0);
      loc_head_q <= (loc_q.size() != 0) ? loc_q[0] : '0;
      fwd_head_q <= (fwd_q.size() != 0) ? fwd_q[0] : '0;
      pending    <= loc_q.size() + fwd_q.size();
   end

   a_loop_known: assert property (@(posedge clk) disable iff (reset) loop_xfer |-> loc_pend_q)
      else begin
         error_count++;
         $error("loop output delivered a beat that no local packet accounts for");
      end

   a_loop_beat: assert property (@(posedge clk) disable iff (reset)
      (loop_xfer && loc_pend_q) |-> (o_loop_tdata == loc_exp_data && o_loop_tlast == loc_exp_last))
      else begin
         error_count++;
         $error("error o_loop_tdata/o_loop_tlast got %h/%h expected %h/%h",
            $sampled(o_loop_tdata), $sampled(o_loop_tlast),
            $sampled(loc_exp_data), $sampled(loc_exp_last));
      end

   a_fwd_known: assert property (@(posedge clk) disable iff (reset) fwd_xfer |-> fwd_avail)
      else begin
         error_count++;
         $error("forward output delivered a beat that no forwarded packet accounts for");
      end

   a_fwd_beat: assert property (@(posedge clk) disable iff (reset)
      (fwd_xfer && fwd_avail) |-> (o_fwd_tdata == fwd_exp_data && o_fwd_tlast == fwd_exp_last))
      else begin
         error_count++;
         $error("error o_fwd_tdata/o_fwd_tlast got %h/%h expected %h/%h",
            $sampled(o_fwd_tdata), $sampled(o_fwd_tlast),
            $sampled(fwd_exp_data), $sampled(fwd_exp_last));
      end

   // A stalled beat has to stay put until it is taken
   a_loop_stable: assert property (@(posedge clk) disable iff (reset)
      (o_loop_tvalid && !i_loop_tready) |=>
      (o_loop_tvalid && $stable(o_loop_tdata) && $stable(o_loop_tlast)))
      else begin
         error_count++;
         $error("loop output dropped or changed a beat while it was stalled");
      end

   a_fwd_stable: assert property (@(posedge clk) disable iff (reset)
      (o_fwd_tvalid && !i_fwd_tready) |=>
      (o_fwd_tvalid && $stable(o_fwd_tdata) && $stable(o_fwd_tlast)))
      else begin
         error_count++;
         $error("forward output dropped or changed a beat while it was stalled");
      end

   a_idle_after_reset: assert property (@(posedge clk)
      $fell(reset) |-> (!o_loop_tvalid && !o_fwd_tvalid))
      else begin
         error_count++;
         $error("an output valid was high in the first cycle after reset");
      end

endmodule

// File: testbench/chdr_loopback_tb.sv
//////////////////////////////////////////////////
// Testbench for the CHDR loopback endpoint. Sends
// LFSR-built packets under random back-pressure;
// the bound checker compares every output beat.
//////////////////////////////////////////////////

module chdr_loopback_tb;

   import chdr_pkg::*;

   localparam ep_addr_t LOCAL_ADDR    = 8'h2a;
   localparam int       FIFO_DEPTH    = 4;
   localparam int       BEAT_TIMEOUT  = 400;
   localparam int       DRAIN_TIMEOUT = 300;

   logic              clk;
   logic              reset;
   logic [DATA_W-1:0] i_tdata;
   logic              i_tlast;
   logic              i_tvalid;
   logic              o_tready;
   logic [DATA_W-1:0] o_loop_tdata;
   logic              o_loop_tlast;
   logic              o_loop_tvalid;
   logic              i_loop_tready;
   logic [DATA_W-1:0] o_fwd_tdata;
   logic              o_fwd_tlast;
   logic              o_fwd_tvalid;
   logic              i_fwd_tready;

   logic [31:0] lfsr_state = 32'h96eb_2e5b;
   logic        stall_phase = 1'b0;
   logic        drain_phase = 1'b0;
   logic        loop_stall_seen = 1'b0;
   int          stall_tick = 0;

   chdr_loopback #(
      .LOCAL_ADDR(LOCAL_ADDR),
      .FIFO_DEPTH(FIFO_DEPTH)
   ) dut_i (
      .clk           (clk),
      .reset         (reset),
      .i_tdata       (i_tdata),
      .i_tlast       (i_tlast),
      .i_tvalid      (i_tvalid),
      .o_tready      (o_tready),
      .o_loop_tdata  (o_loop_tdata),
      .o_loop_tlast  (o_loop_tlast),
      .o_loop_tvalid (o_loop_tvalid),
      .i_loop_tready (i_loop_tready),
      .o_fwd_tdata   (o_fwd_tdata),
      .o_fwd_tlast   (o_fwd_tlast),
      .o_fwd_tvalid  (o_fwd_tvalid),
      .i_fwd_tready  (i_fwd_tready)
   );

   bind chdr_loopback chdr_loopback_chk #(
      .LOCAL_ADDR(LOCAL_ADDR)
   ) chk_i (
      .clk           (clk),
      .reset         (reset),
      .i_tdata       (i_tdata),
      .i_tlast       (i_tlast),
      .i_tvalid      (i_tvalid),
      .o_tready      (o_tready),
      .o_loop_tdata  (o_loop_tdata),
      .o_loop_tlast  (o_loop_tlast),
      .o_loop_tvalid (o_loop_tvalid),
      .i_loop_tready (i_loop_tready),
      .o_fwd_tdata   (o_fwd_tdata),
      .o_fwd_tlast   (o_fwd_tlast),
      .o_fwd_tvalid  (o_fwd_tvalid),
      .i_fwd_tready  (i_fwd_tready)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Galois step for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;
      end
      return s >> 1;
   endfunction

   task automatic rand_bits(input int n, output logic [63:0] bits);
      bits = '0;
      for (int i = 0; i < n; i++) begin
         bits       = {bits[62:0], lfsr_state[0]};
         lfsr_state = lfsr_step(lfsr_state);
      end
   endtask

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1, "simulation stopped on failure");
   endtask

   task automatic drive_readies();
      logic [63:0] r;
      rand_bits(3, r);
      if (drain_phase) begin
         i_loop_tready = 1'b1;
         i_fwd_tready  = 1'b1;
      end else if (stall_phase) begin
         // Long loop stalls with short windows that let a few beats out
         stall_tick++;
         i_loop_tready = (stall_tick % 64) >= 48;
         i_fwd_tready  = r[0] | r[1];
      end else begin
         i_loop_tready = r[2];
         i_fwd_tready  = r[0] | r[1];
      end
   endtask

   task automatic next_edge();
      @(posedge clk);
      #10;
      drive_readies();
   endtask

   // Holds the beat until o_tready, sampled mid-cycle, lets it through
   task automatic send_beat(input logic [DATA_W-1:0] data, input logic last);
      logic accepted;
      int   waited;
      accepted = 1'b0;
      waited   = 0;
      i_tdata  = data;
      i_tlast  = last;
      i_tvalid = 1'b1;
      while (!accepted) begin
         @(negedge clk);
         accepted = o_tready;
         // Forward ready high with o_tready low means the local path is full
         if (!o_tready && i_fwd_tready) begin
            loop_stall_seen = 1'b1;
         end
         next_edge();
         waited++;
         if (!accepted && waited > BEAT_TIMEOUT) begin
            fail_run("an input beat was not accepted within the timeout");
         end
      end
      i_tvalid = 1'b0;
   endtask

   task automatic send_packet();
      int          len;
      ep_addr_t    dst_ep;
      logic [63:0] r;
      logic [63:0] hdr;
      rand_bits(3, r);
      len = int'(r[2:0]) % 6 + 1;
      rand_bits(2, r);
      if (r[0]) begin
         dst_ep = LOCAL_ADDR;
      end else if (r[1]) begin
         dst_ep = 8'h11;
      end else begin
         dst_ep = 8'h5c;
      end
      // Control word and source SID above, destination port below
      rand_bits(56, r);
      hdr = {r[55:8], dst_ep, r[7:0]};
      for (int b = 0; b < len; b++) begin
         rand_bits(2, r);
         if (r[1:0] == 2'b00) begin
            next_edge();
         end
         if (b == 0) begin
            send_beat(hdr, len == 1);
         end else begin
            rand_bits(64, r);
            send_beat(r, b == len - 1);
         end
      end
   endtask

   always @(negedge clk) begin
      if (dut_i.chk_i.error_count != 0) begin
         fail_run("the checker flagged a wrong output beat");
      end
   end

   initial begin
      logic drained;
      int   waited;
      reset         = 1'b1;
      i_tdata       = '0;
      i_tlast       = 1'b0;
      i_tvalid      = 1'b0;
      i_loop_tready = 1'b0;
      i_fwd_tready  = 1'b0;
      repeat (5) @(posedge clk);
      #10;
      reset = 1'b0;
      drive_readies();
      // One idle cycle so both valids can be seen low after reset
      next_edge();
      for (int p = 0; p < 40; p++) begin
         send_packet();
      end
      stall_phase = 1'b1;
      for (int p = 0; p < 25; p++) begin
         send_packet();
      end
      stall_phase = 1'b0;
      drain_phase = 1'b1;
      drained     = 1'b0;
      waited      = 0;
      while (!drained) begin
         @(negedge clk);
         drained = (dut_i.chk_i.pending == 0);
         if (!drained) begin
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
               fail_run("expected beats were still pending after the drain timeout");
            end
            next_edge();
         end
      end
      if (!loop_stall_seen) begin
         fail_run("o_tready never dropped while the loop output was stalled");
      end else if (dut_i.chk_i.error_count != 0) begin
         fail_run("the checker flagged a wrong output beat");
      end else begin
         $display("Test passed");
         $finish;
      end
   end

endmodule

// File: sources.f
rtl/chdr_pkg.sv
rtl/axis_short_fifo.sv
rtl/chdr_dest_demux.sv
rtl/chdr_sid_swap.sv
rtl/chdr_loopback.sv
testbench/chdr_loopback_assertions.sv
testbench/chdr_loopback_tb.sv

// File: Makefile
# Verilator build for the CHDR loopback endpoint

VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert
TOP        = chdr_loopback_tb
FILE_LIST  = sources.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = Test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

# The log decides the result, so the simulator's own status is ignored here
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
